/* verilog/cdb_pkg.sv */
// shared widths, operation codes and bus packets for the writeback slice
// referenced by scoped name from every RTL file and the testbench

package cdb_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	// architectural data word
	localparam int xlen = 32;
	// one memory beat
	localparam int mem_width = 64;

	// physical register file has 64 entries
	typedef logic [5:0] prf_idx_t;
	// reorder buffer has 32 entries
	typedef logic [4:0] rob_idx_t;
	// memory transaction tag, zero means no reply
	typedef logic [3:0] mem_tag_t;

	////////////////////////////////////////
	// encodings
	////////////////////////////////////////

	// integer ops, then conditional branches, then jal
	typedef enum logic [3:0] {
		op_add  = 4'd0,
		op_sub  = 4'd1,
		op_and  = 4'd2,
		op_or   = 4'd3,
		op_xor  = 4'd4,
		op_slt  = 4'd5,
		op_sltu = 4'd6,
		op_sll  = 4'd7,
		op_srl  = 4'd8,
		op_beq  = 4'd9,
		op_bne  = 4'd10,
		op_blt  = 4'd11,
		op_bge  = 4'd12,
		op_jal  = 4'd13
	} alu_op_e;

	// load access size
	typedef enum logic [1:0] {
		size_byte = 2'd0,
		size_half = 2'd1,
		size_word = 2'd2
	} mem_size_e;

	////////////////////////////////////////
	// packets
	////////////////////////////////////////

	// operation handed to the alu lane
	typedef struct packed {
		alu_op_e               op;
		logic [xlen-1:0]       pc;
		logic [xlen-1:0]       rs1_value;
		logic [xlen-1:0]       rs2_value;
		// branch and jal offset
		logic [xlen-1:0]       imm;
		prf_idx_t              dest_prf;
		rob_idx_t              rob_idx;
		logic                  reg_write;
	} issue_packet_t;

	// load registered with the return unit
	typedef struct packed {
		prf_idx_t              dest_prf;
		rob_idx_t              rob_idx;
		mem_size_e             size;
		logic                  is_unsigned;
		// byte position inside the memory beat
		logic [2:0]            offset;
	} load_issue_t;

	// reply from memory
	typedef struct packed {
		mem_tag_t              tag;
		logic [mem_width-1:0]  data;
	} mem_reply_t;

	// one common data bus broadcast
	typedef struct packed {
		logic                  valid;
		logic [xlen-1:0]       data;
		logic [xlen-1:0]       target;
		prf_idx_t              dest_prf;
		rob_idx_t              rob_idx;
		logic                  reg_write;
		// branch taken
		logic                  direction;
	} cdb_packet_t;

endpackage

/* verilog/alu_lane.sv */
// single-entry integer and branch execute stage feeding the cdb merge
// result sits in its output register until the merge takes it

`timescale 1ns/10ps

module alu_lane (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  issue_valid,
	input  cdb_pkg::issue_packet_t issue,
	output logic                  issue_ready,
	input  logic                  alu_taken,
	output cdb_pkg::cdb_packet_t  alu_result
);

	// operation captured at issue
	logic                          ex_valid;
	cdb_pkg::issue_packet_t        ex_op;
	// execute datapath
	logic [cdb_pkg::xlen-1:0]      a;
	logic [cdb_pkg::xlen-1:0]      b;
	logic [cdb_pkg::xlen-1:0]      npc;
	logic [cdb_pkg::xlen-1:0]      branch_target;
	logic [cdb_pkg::xlen-1:0]      result;
	logic                          taken;
	cdb_pkg::cdb_packet_t          next_result;
	logic                          stall;

	// held result not going out this edge
	assign stall       = alu_result.valid & ~alu_taken;
	assign issue_ready = ~stall;

	////////////////////////////////////////
	// execute
	////////////////////////////////////////

	always_comb begin
		a             = ex_op.rs1_value;
		b             = ex_op.rs2_value;
		npc           = ex_op.pc + 32'd4;
		branch_target = ex_op.pc + ex_op.imm;
		result        = '0;
		taken         = 1'b0;
		case (ex_op.op)
			cdb_pkg::op_add:  result = a + b;
			cdb_pkg::op_sub:  result = a - b;
			cdb_pkg::op_and:  result = a & b;
			cdb_pkg::op_or:   result = a | b;
			cdb_pkg::op_xor:  result = a ^ b;
			cdb_pkg::op_slt:  result = {{(cdb_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
			cdb_pkg::op_sltu: result = {{(cdb_pkg::xlen-1){1'b0}}, a < b};
			// only low five bits count as shift amount
			cdb_pkg::op_sll:  result = a << b[4:0];
			cdb_pkg::op_srl:  result = a >> b[4:0];
			// branches carry their target as the result
			cdb_pkg::op_beq: begin
				result = branch_target;
				taken  = (a == b);
			end
			cdb_pkg::op_bne: begin
				result = branch_target;
				taken  = (a != b);
			end
			cdb_pkg::op_blt: begin
				result = branch_target;
				taken  = $signed(a) < $signed(b);
			end
			cdb_pkg::op_bge: begin
				result = branch_target;
				taken  = $signed(a) >= $signed(b);
			end
			cdb_pkg::op_jal: begin
				result = branch_target;
				taken  = 1'b1;
			end
			default: result = '0;
		endcase
	end

	// taken swaps npc onto data and the result onto target
	always_comb begin
		next_result.valid     = ex_valid;
		next_result.data      = taken ? npc : result;
		next_result.target    = taken ? result : npc;
		next_result.dest_prf  = ex_op.dest_prf;
		next_result.rob_idx   = ex_op.rob_idx;
		next_result.reg_write = ex_op.reg_write;
		next_result.direction = taken;
	end

	////////////////////////////////////////
	// issue and hold registers
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			ex_valid <= 1'b0;
		end else if (!stall) begin
			ex_valid <= issue_valid;
		end
	end

	// operand payload only moves on an accepted issue
	always_ff @(posedge clock) begin
		if (issue_valid && issue_ready) begin
			ex_op <= issue;
		end
	end

	// both entries freeze while the merge is busy with a load
	always_ff @(posedge clock) begin
		if (!stall) begin
			alu_result <= next_result;
		end
		if (reset) begin
			alu_result.valid <= 1'b0;
		end
	end

endmodule

/* verilog/load_return.sv */
// tracks outstanding loads by memory tag and turns replies into cdb packets
// tag is slot index plus one, zero on the reply bus means idle

`timescale 1ns/10ps

module load_return #(
	parameter int LOAD_SLOTS = 4
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  load_valid,
	input  cdb_pkg::load_issue_t  load,
	output logic                  load_ready,
	output cdb_pkg::mem_tag_t     load_tag,
	input  cdb_pkg::mem_reply_t   mem_reply,
	output cdb_pkg::cdb_packet_t  load_result
);

	// outstanding load table
	logic [LOAD_SLOTS-1:0]         slot_busy;
	cdb_pkg::load_issue_t          slot_info [LOAD_SLOTS];
	// allocation
	logic                          any_free;
	cdb_pkg::mem_tag_t             free_tag;
	logic                          alloc;
	// reply path
	cdb_pkg::mem_reply_t           reply_q;
	logic                          reply_valid;
	cdb_pkg::load_issue_t          reply_info;
	logic [cdb_pkg::mem_width-1:0] shifted;
	logic [cdb_pkg::xlen-1:0]      load_data;

	////////////////////////////////////////
	// slot allocation
	////////////////////////////////////////

	// scan downward so the lowest free slot wins
	always_comb begin
		any_free = 1'b0;
		free_tag = '0;
		for (int i = LOAD_SLOTS - 1; i >= 0; i--) begin
			if (!slot_busy[i]) begin
				any_free = 1'b1;
				free_tag = cdb_pkg::mem_tag_t'(i + 1);
			end
		end
	end

	assign load_ready = any_free;
	assign load_tag   = free_tag;
	assign alloc      = load_valid & any_free;

	// a slot being freed is still busy, so alloc and free never collide
	always_ff @(posedge clock) begin
		for (int i = 0; i < LOAD_SLOTS; i++) begin
			if (reply_valid && reply_q.tag == cdb_pkg::mem_tag_t'(i + 1)) begin
				slot_busy[i] <= 1'b0;
			end
			if (alloc && free_tag == cdb_pkg::mem_tag_t'(i + 1)) begin
				slot_busy[i] <= 1'b1;
			end
		end
		if (reset) begin
			slot_busy <= '0;
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < LOAD_SLOTS; i++) begin
			if (alloc && free_tag == cdb_pkg::mem_tag_t'(i + 1)) begin
				slot_info[i] <= load;
			end
		end
	end

	////////////////////////////////////////
	// reply extraction
	////////////////////////////////////////

	// reply captured first, extracted on the following edge
	always_ff @(posedge clock) begin
		reply_q <= mem_reply;
		if (reset) begin
			reply_q.tag <= '0;
		end
	end

	assign reply_valid = (reply_q.tag != '0);

	// pick the table entry named by the tag
	always_comb begin
		reply_info = slot_info[0];
		for (int i = 0; i < LOAD_SLOTS; i++) begin
			if (reply_q.tag == cdb_pkg::mem_tag_t'(i + 1)) begin
				reply_info = slot_info[i];
			end
		end
	end

	// addressed bytes down to bit 0, then extend
	assign shifted = reply_q.data >> {reply_info.offset, 3'b000};

	always_comb begin
		case (reply_info.size)
			cdb_pkg::size_byte: begin
				load_data = {{(cdb_pkg::xlen-8){~reply_info.is_unsigned & shifted[7]}},
					shifted[7:0]};
			end
			cdb_pkg::size_half: begin
				load_data = {{(cdb_pkg::xlen-16){~reply_info.is_unsigned & shifted[15]}},
					shifted[15:0]};
			end
			default: load_data = shifted[cdb_pkg::xlen-1:0];
		endcase
	end

	// loads always write a register and never redirect
	always_ff @(posedge clock) begin
		load_result.valid     <= reply_valid;
		load_result.data      <= load_data;
		load_result.target    <= '0;
		load_result.dest_prf  <= reply_info.dest_prf;
		load_result.rob_idx   <= reply_info.rob_idx;
		load_result.reg_write <= 1'b1;
		load_result.direction <= 1'b0;
		if (reset) begin
			load_result.valid <= 1'b0;
		end
	end

endmodule

/* verilog/cdb_merge.sv */
// fixed priority merge of load and alu results onto the common data bus
// the load side always wins while the alu lane holds its result

`timescale 1ns/10ps

module cdb_merge (
	input  logic                 clock,
	input  logic                 reset,
	input  cdb_pkg::cdb_packet_t alu_result,
	input  cdb_pkg::cdb_packet_t load_result,
	output logic                 alu_taken,
	output cdb_pkg::cdb_packet_t cdb
);

	// winner for this edge
	cdb_pkg::cdb_packet_t chosen;

	////////////////////////////////////////
	// arbitration
	////////////////////////////////////////

	// alu only goes out when no load competes
	assign alu_taken = alu_result.valid & ~load_result.valid;

	always_comb begin
		if (load_result.valid) begin
			chosen = load_result;
		end else begin
			// may be an empty packet with valid low
			chosen = alu_result;
		end
	end

	////////////////////////////////////////
	// broadcast register
	////////////////////////////////////////

	// one cycle per broadcast
	always_ff @(posedge clock) begin
		cdb <= chosen;
		if (reset) begin
			cdb.valid <= 1'b0;
		end
	end

endmodule

/* verilog/writeback_slice.sv */
// writeback corner of the core, alu lane and load return meeting on the cdb
// testbench drives issue, load registration and memory replies directly

`timescale 1ns/10ps

module writeback_slice #(
	parameter int LOAD_SLOTS = 4
) (
	input  logic                   clock,
	input  logic                   reset,
	// alu issue
	input  logic                   issue_valid,
	input  cdb_pkg::issue_packet_t issue,
	output logic                   issue_ready,
	// load registration
	input  logic                   load_valid,
	input  cdb_pkg::load_issue_t   load,
	output logic                   load_ready,
	output cdb_pkg::mem_tag_t      load_tag,
	// memory side
	input  cdb_pkg::mem_reply_t    mem_reply,
	// bus broadcast
	output cdb_pkg::cdb_packet_t   cdb
);

	// producer packets into the merge
	cdb_pkg::cdb_packet_t alu_result;
	cdb_pkg::cdb_packet_t load_result;
	logic                 alu_taken;

	alu_lane i_alu_lane (
		.clock       (clock),
		.reset       (reset),
		.issue_valid (issue_valid),
		.issue       (issue),
		.issue_ready (issue_ready),
		.alu_taken   (alu_taken),
		.alu_result  (alu_result)
	);

	load_return #(
		.LOAD_SLOTS (LOAD_SLOTS)
	) i_load_return (
		.clock       (clock),
		.reset       (reset),
		.load_valid  (load_valid),
		.load        (load),
		.load_ready  (load_ready),
		.load_tag    (load_tag),
		.mem_reply   (mem_reply),
		.load_result (load_result)
	);

	cdb_merge i_cdb_merge (
		.clock       (clock),
		.reset       (reset),
		.alu_result  (alu_result),
		.load_result (load_result),
		.alu_taken   (alu_taken),
		.cdb         (cdb)
	);

endmodule

/* testbench/tb_clock_gen.sv */
// clock and synchronous reset source for the writeback slice testbench
// reset stays high for a fixed number of rising edges

`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 4,
	parameter int RESET_CYCLES = 16
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD_NS / 2) clock = ~clock;
	end

	initial begin
		reset <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

/* testbench/tb_writeback_slice.sv */
// random stimulus testbench for the writeback slice
// a cycle model predicts every cdb broadcast, load tag and ready flag

`timescale 1ns/10ps

module tb_writeback_slice;

	localparam int LOAD_SLOTS   = 4;
	localparam int ALU_OPS      = 1000;
	localparam int LOAD_OPS     = 1000;
	localparam int OP_CYCLES    = 20;
	localparam int RESET_CYCLES = 16;

	logic                   clock;
	logic                   reset;
	logic                   issue_valid;
	cdb_pkg::issue_packet_t issue;
	logic                   issue_ready;
	logic                   load_valid;
	cdb_pkg::load_issue_t   load;
	logic                   load_ready;
	cdb_pkg::mem_tag_t      load_tag;
	cdb_pkg::mem_reply_t    mem_reply;
	cdb_pkg::cdb_packet_t   cdb;

	// expected broadcasts keyed by rob_idx
	cdb_pkg::cdb_packet_t   expect_by_rob [32];
	logic                   rob_busy [32];
	// alu results in issue order with their accept edge
	int                     alu_order [$];
	int                     alu_accept_edge [$];
	// load broadcasts, edge they are due and their rob
	int                     due_edge [$];
	int                     due_rob [$];
	// slot state 0 free, 1 waiting for reply, 2 replied and freeing
	int                     slot_state [LOAD_SLOTS];
	int                     slot_ready_edge [LOAD_SLOTS];
	int                     slot_free_edge [LOAD_SLOTS];
	cdb_pkg::load_issue_t   slot_load [LOAD_SLOTS];
	// values for the next rising edge
	logic                   next_issue_valid;
	cdb_pkg::issue_packet_t next_issue;
	logic                   next_load_valid;
	cdb_pkg::load_issue_t   next_load;
	cdb_pkg::mem_reply_t    next_reply;
	int                     next_rob;
	int                     alus_planned;
	int                     alus_done;
	int                     loads_planned;
	int                     loads_done;
	int                     replies_done;
	int                     taken_count;
	int                     compete_count;

	tb_clock_gen #(
		.PERIOD_NS    (4),
		.RESET_CYCLES (RESET_CYCLES)
	) i_clock_gen (
		.clock (clock),
		.reset (reset)
	);

	writeback_slice #(
		.LOAD_SLOTS (LOAD_SLOTS)
	) i_dut (
		.clock       (clock),
		.reset       (reset),
		.issue_valid (issue_valid),
		.issue       (issue),
		.issue_ready (issue_ready),
		.load_valid  (load_valid),
		.load        (load),
		.load_ready  (load_ready),
		.load_tag    (load_tag),
		.mem_reply   (mem_reply),
		.cdb         (cdb)
	);

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	function automatic cdb_pkg::cdb_packet_t alu_model(input cdb_pkg::issue_packet_t p);
		cdb_pkg::cdb_packet_t r;
		logic [31:0]          seq_pc;
		logic [31:0]          jump_pc;
		logic                 signed_less;
		logic                 go;
		seq_pc  = p.pc + 32'd4;
		jump_pc = p.pc + p.imm;
		// differing sign bits, the negative one is smaller
		signed_less = (p.rs1_value[31] != p.rs2_value[31]) ? p.rs1_value[31] :
			(p.rs1_value < p.rs2_value);
		go          = 1'b0;
		r           = '0;
		r.valid     = 1'b1;
		r.dest_prf  = p.dest_prf;
		r.rob_idx   = p.rob_idx;
		r.reg_write = p.reg_write;
		r.target    = seq_pc;
		case (p.op)
			cdb_pkg::op_add:  r.data = p.rs1_value + p.rs2_value;
			cdb_pkg::op_sub:  r.data = p.rs1_value - p.rs2_value;
			cdb_pkg::op_and:  r.data = p.rs1_value & p.rs2_value;
			cdb_pkg::op_or:   r.data = p.rs1_value | p.rs2_value;
			cdb_pkg::op_xor:  r.data = p.rs1_value ^ p.rs2_value;
			cdb_pkg::op_slt:  r.data = {31'b0, signed_less};
			cdb_pkg::op_sltu: r.data = {31'b0, p.rs1_value < p.rs2_value};
			cdb_pkg::op_sll:  r.data = p.rs1_value << p.rs2_value[4:0];
			cdb_pkg::op_srl:  r.data = p.rs1_value >> p.rs2_value[4:0];
			cdb_pkg::op_beq:  go = (p.rs1_value == p.rs2_value);
			cdb_pkg::op_bne:  go = (p.rs1_value != p.rs2_value);
			cdb_pkg::op_blt:  go = signed_less;
			cdb_pkg::op_bge:  go = ~signed_less;
			cdb_pkg::op_jal:  go = 1'b1;
			default:          r.data = '0;
		endcase
		// taken puts the return address on data and the jump on target
		if (p.op >= cdb_pkg::op_beq) begin
			r.data      = go ? seq_pc : jump_pc;
			r.target    = go ? jump_pc : seq_pc;
			r.direction = go;
		end
		return r;
	endfunction

	function automatic cdb_pkg::cdb_packet_t load_model(input cdb_pkg::load_issue_t l,
		input logic [63:0] word);
		cdb_pkg::cdb_packet_t r;
		int                   nbytes;
		logic                 fill;
		r           = '0;
		r.valid     = 1'b1;
		r.dest_prf  = l.dest_prf;
		r.rob_idx   = l.rob_idx;
		r.reg_write = 1'b1;
		nbytes = (l.size == cdb_pkg::size_byte) ? 1 : (l.size == cdb_pkg::size_half) ? 2 : 4;
		for (int i = 0; i < nbytes; i++) begin
			r.data[8*i +: 8] = word[8*(int'(l.offset) + i) +: 8];
		end
		fill = ~l.is_unsigned & r.data[8*nbytes-1];
		for (int i = nbytes; i < 4; i++) begin
			r.data[8*i +: 8] = {8{fill}};
		end
		return r;
	endfunction

	function automatic cdb_pkg::issue_packet_t random_issue(input int rob);
		cdb_pkg::issue_packet_t p;
		p.op        = cdb_pkg::alu_op_e'($urandom_range(0, 13));
		p.pc        = $urandom & 32'hffff_fffc;
		p.rs1_value = $urandom;
		// equal operands often enough to flip beq and bne
		p.rs2_value = ($urandom_range(0, 3) == 0) ? p.rs1_value : $urandom;
		p.imm       = $urandom;
		p.dest_prf  = cdb_pkg::prf_idx_t'($urandom);
		p.rob_idx   = cdb_pkg::rob_idx_t'(rob);
		p.reg_write = 1'($urandom_range(0, 1));
		return p;
	endfunction

	function automatic cdb_pkg::load_issue_t random_load(input int rob);
		cdb_pkg::load_issue_t l;
		l.dest_prf    = cdb_pkg::prf_idx_t'($urandom);
		l.rob_idx     = cdb_pkg::rob_idx_t'(rob);
		l.size        = cdb_pkg::mem_size_e'($urandom_range(0, 2));
		l.is_unsigned = 1'($urandom_range(0, 1));
		// access stays inside the 64-bit beat
		case (l.size)
			cdb_pkg::size_byte: l.offset = 3'($urandom_range(0, 7));
			cdb_pkg::size_half: l.offset = 3'($urandom_range(0, 6));
			default:            l.offset = 3'($urandom_range(0, 4));
		endcase
		return l;
	endfunction

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic check_cdb(input string name, input cdb_pkg::cdb_packet_t exp,
		input cdb_pkg::cdb_packet_t act);
		// idle bus, payload is don't care
		if (exp.valid ? (act !== exp) : (act.valid !== 1'b0)) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_tag(input string name, input cdb_pkg::mem_tag_t exp,
		input cdb_pkg::mem_tag_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %0d actual %0d", name, exp, act);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %b actual %b", name, exp, act);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	////////////////////////////////////////
	// per cycle model steps
	////////////////////////////////////////

	// slot cleared by the dut on an edge before e
	task automatic release_slots(input int e);
		for (int s = 0; s < LOAD_SLOTS; s++) begin
			if (slot_state[s] == 2 && slot_free_edge[s] <= e - 1) begin
				slot_state[s] = 0;
			end
		end
	endtask

	// cdb as registered on edge c
	task automatic check_bus(input int c);
		cdb_pkg::cdb_packet_t idle;
		logic                 alu_due;
		idle    = '0;
		alu_due = (alu_order.size() > 0) && (alu_accept_edge[0] <= c - 2);
		if (due_edge.size() > 0 && due_edge[0] == c) begin
			if (alu_due) begin
				compete_count++;
			end
			check_cdb("load broadcast", expect_by_rob[due_rob[0]], cdb);
			rob_busy[due_rob[0]] = 1'b0;
			void'(due_edge.pop_front());
			void'(due_rob.pop_front());
		end else if (alu_due) begin
			check_cdb("alu broadcast", expect_by_rob[alu_order[0]], cdb);
			rob_busy[alu_order[0]] = 1'b0;
			void'(alu_order.pop_front());
			void'(alu_accept_edge.pop_front());
		end else begin
			check_cdb("idle bus", idle, cdb);
		end
	endtask

	// ready flags and tag seen before edge e
	task automatic check_ready(input int e);
		int   busy;
		int   lowest;
		logic held;
		busy   = 0;
		lowest = -1;
		for (int s = 0; s < LOAD_SLOTS; s++) begin
			if (slot_state[s] != 0) begin
				busy++;
			end else if (lowest < 0) begin
				lowest = s;
			end
		end
		check_flag("load ready", busy < LOAD_SLOTS, load_ready);
		check_tag("load tag", cdb_pkg::mem_tag_t'(lowest + 1), load_tag);
		// held alu result blocked by a load going out
		held = (alu_order.size() > 0) && (alu_accept_edge[0] <= e - 2);
		check_flag("issue ready", ~(held && due_edge.size() > 0 && due_edge[0] == e), issue_ready);
	endtask

	// what the dut takes on edge e
	task automatic sample_handshakes(input int e);
		int slot;
		if (issue_valid && issue_ready) begin
			expect_by_rob[issue.rob_idx] = alu_model(issue);
			taken_count += int'(expect_by_rob[issue.rob_idx].direction);
			alu_order.push_back(int'(issue.rob_idx));
			alu_accept_edge.push_back(e);
			alus_done++;
		end
		if (load_valid && load_ready) begin
			slot                  = int'(load_tag) - 1;
			slot_state[slot]      = 1;
			slot_load[slot]       = load;
			slot_ready_edge[slot] = e + 1 + int'($urandom_range(0, 12));
			loads_done++;
		end
		if (mem_reply.tag != '0) begin
			slot = int'(mem_reply.tag) - 1;
			expect_by_rob[slot_load[slot].rob_idx] = load_model(slot_load[slot], mem_reply.data);
			due_edge.push_back(e + 2);
			due_rob.push_back(int'(slot_load[slot].rob_idx));
			slot_state[slot]     = 2;
			slot_free_edge[slot] = e + 1;
			replies_done++;
		end
	endtask

	// inputs for edge e+1, a refused request is held unchanged
	task automatic plan_inputs(input int e);
		int eligible [$];
		int pick;
		next_issue_valid = issue_valid;
		next_issue       = issue;
		next_load_valid  = load_valid;
		next_load        = load;
		if (!(issue_valid && !issue_ready)) begin
			next_issue_valid = 1'b0;
			if (alus_planned < ALU_OPS && $urandom_range(0, 1) == 1 && !rob_busy[next_rob]) begin
				next_issue_valid  = 1'b1;
				next_issue        = random_issue(next_rob);
				rob_busy[next_rob] = 1'b1;
				next_rob          = (next_rob + 1) % 32;
				alus_planned++;
			end
		end
		if (!(load_valid && !load_ready)) begin
			next_load_valid = 1'b0;
			if (loads_planned < LOAD_OPS && $urandom_range(0, 1) == 1 && !rob_busy[next_rob]) begin
				next_load_valid    = 1'b1;
				next_load          = random_load(next_rob);
				rob_busy[next_rob] = 1'b1;
				next_rob           = (next_rob + 1) % 32;
				loads_planned++;
			end
		end
		// idle beats carry junk data too
		next_reply.tag  = '0;
		next_reply.data = {$urandom, $urandom};
		for (int s = 0; s < LOAD_SLOTS; s++) begin
			if (slot_state[s] == 1 && slot_ready_edge[s] <= e + 1) begin
				eligible.push_back(s);
			end
		end
		if (eligible.size() > 0 && $urandom_range(0, 2) != 0) begin
			pick           = eligible[$urandom_range(0, eligible.size() - 1)];
			next_reply.tag = cdb_pkg::mem_tag_t'(pick + 1);
		end
	endtask

	////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////

	initial begin
		int edge_idx;
		int idle_tail;
		void'($urandom(32'hbfc6_2496));
		issue_valid <= 1'b0;
		issue       <= '0;
		load_valid  <= 1'b0;
		load        <= '0;
		mem_reply   <= '0;
		for (int i = 0; i < 32; i++) begin
			rob_busy[i] = 1'b0;
		end
		for (int s = 0; s < LOAD_SLOTS; s++) begin
			slot_state[s] = 0;
		end
		next_rob      = 0;
		alus_planned  = 0;
		alus_done     = 0;
		loads_planned = 0;
		loads_done    = 0;
		replies_done  = 0;
		taken_count   = 0;
		compete_count = 0;
		@(negedge clock);
		while (reset) begin
			@(negedge clock);
		end
		// edge 0 is the last one that saw reset
		edge_idx  = 1;
		idle_tail = 0;
		while (idle_tail < 8) begin
			release_slots(edge_idx);
			check_bus(edge_idx - 1);
			check_ready(edge_idx);
			sample_handshakes(edge_idx);
			plan_inputs(edge_idx);
			if (alus_done == ALU_OPS && loads_done == LOAD_OPS && replies_done == LOAD_OPS &&
				alu_order.size() == 0 && due_edge.size() == 0) begin
				idle_tail++;
			end
			@(posedge clock);
			issue_valid <= next_issue_valid;
			issue       <= next_issue;
			load_valid  <= next_load_valid;
			load        <= next_load;
			mem_reply   <= next_reply;
			edge_idx++;
			@(negedge clock);
		end
		$display("%0d alu ops, %0d taken, %0d loads, %0d load over alu conflicts",
			alus_done, taken_count, loads_done, compete_count);
		$display("ALL CHECKS PASSED");
		$finish;
	end

	initial begin
		repeat (RESET_CYCLES + (ALU_OPS + LOAD_OPS) * OP_CYCLES) @(posedge clock);
		$display("run timed out before all results returned");
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

/* all.f */
verilog/cdb_pkg.sv
verilog/alu_lane.sv
verilog/load_return.sv
verilog/cdb_merge.sv
verilog/writeback_slice.sv
testbench/tb_clock_gen.sv
testbench/tb_writeback_slice.sv

/* run.sh */
#!/bin/sh
# build and run the writeback slice testbench with verilator
# exit status is nonzero when the simulation ends through $fatal
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_writeback_slice -f all.f
./obj_dir/Vtb_writeback_slice
